// File: logic/dma_pkg.sv
`default_nettype none

package dma_pkg;

    // bus and word widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 8;
    localparam int ID_W   = 4;

    // burst sizing, stride is in bytes
    localparam int MAX_BEATS    = 256;
    localparam int BURST_STRIDE = 1024;

    // 4-byte beats
    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

    // only INCR is ever issued
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } axi_burst_e;

    // burst controller states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        CHECK = 3'd1,
        AR_CH = 3'd2,
        AW_CH = 3'd3,
        BUSY  = 3'd4,
        B_CH  = 3'd5,
        FIN   = 3'd6
    } dma_state_e;

    // register word offsets
    typedef enum logic [2:0] {
        SRC    = 3'd0,
        DST    = 3'd1,
        QTY    = 3'd2,
        CTRL   = 3'd3,
        STATUS = 3'd4
    } reg_addr_e;

endpackage

`default_nettype wire

// File: logic/dma_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module dma_fifo import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              clr_i,
    input  wire logic              wen_i,
    input  wire logic              ren_i,
    input  wire logic [DATA_W-1:0] data_i,
    output logic      [DATA_W-1:0] data_o,
    output logic                   empty_o,
    output logic                   full_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_wr;
    logic              do_rd;

    // guarded so a bad strobe never corrupts the pointers
    assign do_wr = wen_i && !full_o;
    assign do_rd = ren_i && !empty_o;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(FIFO_DEPTH));

    // head word straight from the array
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy holds when both sides move
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dma_master.sv
`timescale 1ns/10ps
`default_nettype none

module dma_master import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int DMA_ID     = 0
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              dma_start_i,
    input  wire logic [ADDR_W-1:0] src_addr_i,
    input  wire logic [ADDR_W-1:0] dst_addr_i,
    input  wire logic [DATA_W-1:0] word_qty_i,
    output logic                   dma_fin_o,
    // read address
    output logic      [ID_W-1:0]   arid_o,
    output logic      [ADDR_W-1:0] araddr_o,
    output logic      [LEN_W-1:0]  arlen_o,
    output logic      [2:0]        arsize_o,
    output logic      [1:0]        arburst_o,
    output logic                   arvalid_o,
    input  wire logic              arready_i,
    // read data
    input  wire logic [DATA_W-1:0] rdata_i,
    input  wire logic              rlast_i,
    input  wire logic              rvalid_i,
    output logic                   rready_o,
    // write address
    output logic      [ID_W-1:0]   awid_o,
    output logic      [ADDR_W-1:0] awaddr_o,
    output logic      [LEN_W-1:0]  awlen_o,
    output logic      [2:0]        awsize_o,
    output logic      [1:0]        awburst_o,
    output logic                   awvalid_o,
    input  wire logic              awready_i,
    // write data
    output logic      [DATA_W-1:0] wdata_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  wire logic              wready_i,
    // write response
    input  wire logic              bvalid_i,
    output logic                   bready_o
);

    dma_state_e state, next;

    logic [DATA_W-1:0] rem_qty_r;
    logic [LEN_W:0]    beats_r;
    logic [ADDR_W-1:0] src_addr_r;
    logic [ADDR_W-1:0] dst_addr_r;
    logic [DATA_W-1:0] rem_left;
    logic [LEN_W:0]    len_full;
    logic [LEN_W-1:0]  axlen;

    // beat counters within the current burst
    logic [LEN_W-1:0]  rcnt;
    logic [LEN_W-1:0]  wcnt;
    logic              rd_open_r;

    logic arhns, awhns, rhns, whns, bhns;
    logic wrfin;

    logic [DATA_W-1:0] fifo_dout;
    logic              fifo_wen, fifo_ren;
    logic              fifo_empty, fifo_full;

    // smaller of MAX_BEATS and the words still to move
    function automatic logic [LEN_W:0] burst_beats(input logic [DATA_W-1:0] qty);
        if (qty >= DATA_W'(MAX_BEATS)) begin
            return MAX_BEATS[LEN_W:0];
        end
        return qty[LEN_W:0];
    endfunction

    assign arhns = arvalid_o && arready_i;
    assign awhns = awvalid_o && awready_i;
    assign rhns  = rvalid_i  && rready_o;
    assign whns  = wvalid_o  && wready_i;
    assign bhns  = bvalid_i  && bready_o;
    assign wrfin = whns && wlast_o;

    assign rem_left = rem_qty_r - DATA_W'(beats_r);
    assign len_full = beats_r - 1'b1;
    assign axlen    = len_full[LEN_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            IDLE:    next = dma_start_i ? CHECK : IDLE;
            CHECK:   next = (rem_qty_r != '0) ? AR_CH : FIN;
            AR_CH:   next = arhns ? AW_CH : AR_CH;
            AW_CH:   next = awhns ? BUSY : AW_CH;
            BUSY:    next = wrfin ? B_CH : BUSY;
            // last burst when nothing remains after this one
            B_CH:    next = !bhns ? B_CH : ((rem_left == '0) ? FIN : AR_CH);
            FIN:     next = IDLE;
            default: next = IDLE;
        endcase
    end

    assign dma_fin_o = (state == FIN);

    // transfer bookkeeping, updated once per burst after the response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem_qty_r  <= '0;
            beats_r    <= '0;
            src_addr_r <= '0;
            dst_addr_r <= '0;
        end else if (state == IDLE && dma_start_i) begin
            rem_qty_r  <= word_qty_i;
            beats_r    <= burst_beats(word_qty_i);
            src_addr_r <= src_addr_i;
            dst_addr_r <= dst_addr_i;
        end else if (state == B_CH && bhns) begin
            rem_qty_r  <= rem_left;
            beats_r    <= burst_beats(rem_left);
            src_addr_r <= src_addr_r + ADDR_W'(BURST_STRIDE);
            dst_addr_r <= dst_addr_r + ADDR_W'(BURST_STRIDE);
        end
    end

    // read side stops at rlast or after axlen+1 beats, whichever first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rcnt      <= '0;
            rd_open_r <= 1'b0;
        end else if (awhns) begin
            rcnt      <= '0;
            rd_open_r <= 1'b1;
        end else if (rhns) begin
            rcnt <= rcnt + 1'b1;
            if (rlast_i || rcnt == axlen) begin
                rd_open_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wcnt <= '0;
        end else if (awhns) begin
            wcnt <= '0;
        end else if (whns) begin
            wcnt <= wcnt + 1'b1;
        end
    end

    assign arid_o    = ID_W'(DMA_ID);
    assign araddr_o  = src_addr_r;
    assign arlen_o   = axlen;
    assign arsize_o  = AXI_SIZE_WORD;
    assign arburst_o = INCR;
    assign arvalid_o = (state == AR_CH);

    assign awid_o    = ID_W'(DMA_ID);
    assign awaddr_o  = dst_addr_r;
    assign awlen_o   = axlen;
    assign awsize_o  = AXI_SIZE_WORD;
    assign awburst_o = INCR;
    assign awvalid_o = (state == AW_CH);

    // back-pressure through the FIFO flags
    assign rready_o = (state == BUSY) && rd_open_r && !fifo_full;
    assign wvalid_o = (state == BUSY) && !fifo_empty;
    assign wdata_o  = fifo_dout;
    assign wlast_o  = (wcnt == axlen);
    assign bready_o = (state == B_CH);

    assign fifo_wen = rhns;
    assign fifo_ren = whns;

    dma_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .clr_i   (dma_fin_o),
        .wen_i   (fifo_wen),
        .ren_i   (fifo_ren),
        .data_i  (rdata_i),
        .data_o  (fifo_dout),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

endmodule

`default_nettype wire

// File: logic/dma_regs.sv
`timescale 1ns/10ps
`default_nettype none

module dma_regs import dma_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              reg_we_i,
    input  wire logic              reg_re_i,
    input  wire logic [2:0]        reg_addr_i,
    input  wire logic [DATA_W-1:0] reg_wdata_i,
    output logic      [DATA_W-1:0] reg_rdata_o,
    output logic      [ADDR_W-1:0] src_addr_o,
    output logic      [ADDR_W-1:0] dst_addr_o,
    output logic      [DATA_W-1:0] word_qty_o,
    output logic                   dma_start_o,
    input  wire logic              dma_fin_i,
    output logic                   irq_o
);

    logic [ADDR_W-1:0] src_r;
    logic [ADDR_W-1:0] dst_r;
    logic [DATA_W-1:0] qty_r;
    logic              busy_r;
    logic              done_r;
    logic              start_r;
    logic [DATA_W-1:0] rdata_r;
    logic              cfg_we;
    logic              ctrl_we;
    logic              start_req;

    // configuration is frozen while a transfer runs
    assign cfg_we    = reg_we_i && !busy_r;
    assign ctrl_we   = reg_we_i && (reg_addr_i == CTRL);
    assign start_req = ctrl_we && reg_wdata_i[0] && !busy_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_r <= '0;
            dst_r <= '0;
            qty_r <= '0;
        end else if (cfg_we) begin
            case (reg_addr_i)
                SRC:     src_r <= reg_wdata_i;
                DST:     dst_r <= reg_wdata_i;
                QTY:     qty_r <= reg_wdata_i;
                default: ;
            endcase
        end
    end

    // start pulse and busy rise on the same edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_r <= 1'b0;
            busy_r  <= 1'b0;
        end else begin
            start_r <= start_req;
            if (start_req) begin
                busy_r <= 1'b1;
            end else if (dma_fin_i) begin
                busy_r <= 1'b0;
            end
        end
    end

    // finish wins over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_r <= 1'b0;
        end else if (dma_fin_i) begin
            done_r <= 1'b1;
        end else if (ctrl_we && reg_wdata_i[1]) begin
            done_r <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_r <= '0;
        end else if (reg_re_i) begin
            case (reg_addr_i)
                SRC:     rdata_r <= src_r;
                DST:     rdata_r <= dst_r;
                QTY:     rdata_r <= qty_r;
                STATUS:  rdata_r <= {{(DATA_W - 2){1'b0}}, done_r, busy_r};
                default: rdata_r <= '0;
            endcase
        end
    end

    assign reg_rdata_o = rdata_r;
    assign src_addr_o  = src_r;
    assign dst_addr_o  = dst_r;
    assign word_qty_o  = qty_r;
    assign dma_start_o = start_r;
    assign irq_o       = done_r;

endmodule

`default_nettype wire

// File: logic/dma_top.sv
`timescale 1ns/10ps
`default_nettype none

module dma_top import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int DMA_ID     = 0
) (
    input  wire logic              clk,
    input  wire logic              rst,
    // CPU register port
    input  wire logic              reg_we_i,
    input  wire logic              reg_re_i,
    input  wire logic [2:0]        reg_addr_i,
    input  wire logic [DATA_W-1:0] reg_wdata_i,
    output logic      [DATA_W-1:0] reg_rdata_o,
    output logic                   irq_o,
    // AXI4 master
    output logic      [ID_W-1:0]   arid_o,
    output logic      [ADDR_W-1:0] araddr_o,
    output logic      [LEN_W-1:0]  arlen_o,
    output logic      [2:0]        arsize_o,
    output logic      [1:0]        arburst_o,
    output logic                   arvalid_o,
    input  wire logic              arready_i,
    input  wire logic [DATA_W-1:0] rdata_i,
    input  wire logic              rlast_i,
    input  wire logic              rvalid_i,
    output logic                   rready_o,
    output logic      [ID_W-1:0]   awid_o,
    output logic      [ADDR_W-1:0] awaddr_o,
    output logic      [LEN_W-1:0]  awlen_o,
    output logic      [2:0]        awsize_o,
    output logic      [1:0]        awburst_o,
    output logic                   awvalid_o,
    input  wire logic              awready_i,
    output logic      [DATA_W-1:0] wdata_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  wire logic              wready_i,
    input  wire logic              bvalid_i,
    output logic                   bready_o
);

    logic              dma_start;
    logic              dma_fin;
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dst_addr;
    logic [DATA_W-1:0] word_qty;

    dma_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_we_i    (reg_we_i),
        .reg_re_i    (reg_re_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .src_addr_o  (src_addr),
        .dst_addr_o  (dst_addr),
        .word_qty_o  (word_qty),
        .dma_start_o (dma_start),
        .dma_fin_i   (dma_fin),
        .irq_o       (irq_o)
    );

    dma_master #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .DMA_ID     (DMA_ID)
    ) u_master (
        .clk         (clk),
        .rst         (rst),
        .dma_start_i (dma_start),
        .src_addr_i  (src_addr),
        .dst_addr_i  (dst_addr),
        .word_qty_i  (word_qty),
        .dma_fin_o   (dma_fin),
        .arid_o      (arid_o),
        .araddr_o    (araddr_o),
        .arlen_o     (arlen_o),
        .arsize_o    (arsize_o),
        .arburst_o   (arburst_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .rdata_i     (rdata_i),
        .rlast_i     (rlast_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .awid_o      (awid_o),
        .awaddr_o    (awaddr_o),
        .awlen_o     (awlen_o),
        .awsize_o    (awsize_o),
        .awburst_o   (awburst_o),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .wdata_o     (wdata_o),
        .wlast_o     (wlast_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o)
    );

endmodule

`default_nettype wire

// File: testbench/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model import dma_pkg::*; #(
    parameter int MEM_WORDS = 8192
) (
    input  wire logic              clk,
    input  wire logic              rst,
    // one stall bit per channel: ar, aw, r, w, b
    input  wire logic [4:0]        stall_i,
    input  wire logic [ADDR_W-1:0] exp_src_i,
    input  wire logic [ADDR_W-1:0] exp_dst_i,
    input  wire logic [DATA_W-1:0] exp_qty_i,
    input  wire logic              cnt_clr_i,
    output logic      [31:0]       ar_cnt_o,
    output logic      [31:0]       aw_cnt_o,
    output logic                   err_o,
    input  wire logic [ADDR_W-1:0] araddr_i,
    input  wire logic [LEN_W-1:0]  arlen_i,
    input  wire logic              arvalid_i,
    output logic                   arready_o,
    output logic      [DATA_W-1:0] rdata_o,
    output logic                   rlast_o,
    output logic                   rvalid_o,
    input  wire logic              rready_i,
    input  wire logic [ADDR_W-1:0] awaddr_i,
    input  wire logic [LEN_W-1:0]  awlen_i,
    input  wire logic              awvalid_i,
    output logic                   awready_o,
    input  wire logic [DATA_W-1:0] wdata_i,
    input  wire logic              wlast_i,
    input  wire logic              wvalid_i,
    output logic                   wready_o,
    output logic                   bvalid_o,
    input  wire logic              bready_i
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic [LEN_W:0]    rd_left;
    logic [LEN_W:0]    wr_beat;
    logic [LEN_W:0]    wr_beats;
    logic              rd_busy;
    logic              wr_busy;
    logic              b_pend;
    // valid still waiting for its ready
    logic              r_hold;
    logic              b_hold;

    function automatic logic [ADDR_W-1:0] burst_addr(input logic [ADDR_W-1:0] base,
                                                     input logic [31:0] n);
        return base + n * ADDR_W'(BURST_STRIDE);
    endfunction

    // burst n moves min(256, words left) beats
    function automatic logic [LEN_W-1:0] burst_len(input logic [31:0] n);
        logic [DATA_W-1:0] rem;
        rem = exp_qty_i - n * DATA_W'(MAX_BEATS);
        if (rem > DATA_W'(MAX_BEATS)) begin
            rem = DATA_W'(MAX_BEATS);
        end
        return LEN_W'(rem - 32'd1);
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_idx   <= '0;
            wr_idx   <= '0;
            rd_left  <= '0;
            wr_beat  <= '0;
            wr_beats <= '0;
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            b_pend   <= 1'b0;
            r_hold   <= 1'b0;
            b_hold   <= 1'b0;
            ar_cnt_o <= '0;
            aw_cnt_o <= '0;
            err_o    <= 1'b0;
        end else begin
            r_hold <= rvalid_o && !rready_i;
            b_hold <= bvalid_o && !bready_i;
            if (cnt_clr_i) begin
                ar_cnt_o <= '0;
                aw_cnt_o <= '0;
            end
            if (arvalid_i && arready_o) begin
                assert (ar_cnt_o * DATA_W'(MAX_BEATS) < exp_qty_i) else begin
                    $display("read burst %0d requested beyond the word count at %0t",
                             ar_cnt_o, $time);
                    err_o <= 1'b1;
                end
                assert (araddr_i == burst_addr(exp_src_i, ar_cnt_o)) else begin
                    $display("mismatch at %0t: araddr got %h expected %h",
                             $time, araddr_i, burst_addr(exp_src_i, ar_cnt_o));
                    err_o <= 1'b1;
                end
                assert (arlen_i == burst_len(ar_cnt_o)) else begin
                    $display("mismatch at %0t: arlen got %0d expected %0d",
                             $time, arlen_i, burst_len(ar_cnt_o));
                    err_o <= 1'b1;
                end
                rd_idx   <= araddr_i[IDX_W+1:2];
                rd_left  <= {1'b0, arlen_i} + 1'b1;
                rd_busy  <= 1'b1;
                ar_cnt_o <= ar_cnt_o + 1;
            end
            if (rvalid_o && rready_i) begin
                rd_idx  <= rd_idx + 1'b1;
                rd_left <= rd_left - 1'b1;
                if (rd_left == 9'd1) begin
                    rd_busy <= 1'b0;
                end
            end
            if (awvalid_i && awready_o) begin
                assert (aw_cnt_o * DATA_W'(MAX_BEATS) < exp_qty_i) else begin
                    $display("write burst %0d requested beyond the word count at %0t",
                             aw_cnt_o, $time);
                    err_o <= 1'b1;
                end
                assert (awaddr_i == burst_addr(exp_dst_i, aw_cnt_o)) else begin
                    $display("mismatch at %0t: awaddr got %h expected %h",
                             $time, awaddr_i, burst_addr(exp_dst_i, aw_cnt_o));
                    err_o <= 1'b1;
                end
                assert (awlen_i == burst_len(aw_cnt_o)) else begin
                    $display("mismatch at %0t: awlen got %0d expected %0d",
                             $time, awlen_i, burst_len(aw_cnt_o));
                    err_o <= 1'b1;
                end
                wr_idx   <= awaddr_i[IDX_W+1:2];
                wr_beats <= {1'b0, awlen_i} + 1'b1;
                wr_beat  <= '0;
                wr_busy  <= 1'b1;
                aw_cnt_o <= aw_cnt_o + 1;
            end
            if (wvalid_i && wready_o) begin
                mem[wr_idx] = wdata_i;
                assert (wlast_i == (wr_beat == wr_beats - 1'b1)) else begin
                    $display("mismatch at %0t: wlast got %b expected %b",
                             $time, wlast_i, wr_beat == wr_beats - 1'b1);
                    err_o <= 1'b1;
                end
                wr_idx  <= wr_idx + 1'b1;
                wr_beat <= wr_beat + 1'b1;
                if (wlast_i) begin
                    wr_busy <= 1'b0;
                    b_pend  <= 1'b1;
                end
            end
            if (bvalid_o && bready_i) begin
                b_pend <= 1'b0;
            end
        end
    end

    // slave outputs change on the falling edge
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rlast_o   <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
        end else begin
            arready_o <= !rd_busy && !stall_i[0];
            awready_o <= !wr_busy && !b_pend && !stall_i[1];
            rvalid_o  <= rd_busy && (r_hold || !stall_i[2]);
            rdata_o   <= mem[rd_idx];
            rlast_o   <= (rd_left == 9'd1);
            wready_o  <= wr_busy && !stall_i[3];
            bvalid_o  <= b_pend && (b_hold || !stall_i[4]);
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_dma_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dma_top import dma_pkg::*; ();

    localparam int NUM_TESTS  = 6;
    localparam int MEM_WORDS  = 8192;
    localparam int HALF_WORDS = MEM_WORDS / 2;
    localparam int MAX_QTY    = 700;
    localparam int AXI_ID     = 3;
    localparam logic [31:0] SEED = 32'h828d;

    logic              clk = 1'b0;
    logic              rst;
    logic              reg_we;
    logic              reg_re;
    logic [2:0]        reg_addr;
    logic [DATA_W-1:0] reg_wdata;
    logic [DATA_W-1:0] reg_rdata;
    logic              irq;

    logic [ADDR_W-1:0] araddr, awaddr;
    logic [LEN_W-1:0]  arlen, awlen;
    logic              arvalid, arready, rvalid, rready, rlast;
    logic              awvalid, awready, wvalid, wready, wlast;
    logic              bvalid, bready;
    logic [DATA_W-1:0] rdata, wdata;
    logic [ID_W-1:0]   arid, awid;
    logic [2:0]        arsize, awsize;
    logic [1:0]        arburst, awburst;

    logic [4:0]        stall;
    logic              stall_en;
    logic [31:0]       stall_rng = SEED;
    logic [ADDR_W-1:0] exp_src, exp_dst;
    logic [DATA_W-1:0] exp_qty;
    logic              cnt_clr;
    logic [31:0]       ar_cnt, aw_cnt;
    logic              model_err;

    logic [31:0]       rng;
    int unsigned       qty_tab [NUM_TESTS];
    int unsigned       src_tab [NUM_TESTS];
    int unsigned       dst_tab [NUM_TESTS];
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    longint            cycles = 0;
    longint            limit = 0;

    always #20 clk = ~clk;

    dma_top #(
        .FIFO_DEPTH (4),
        .DMA_ID     (AXI_ID)
    ) dma_top_i (
        .clk (clk), .rst (rst),
        .reg_we_i (reg_we), .reg_re_i (reg_re), .reg_addr_i (reg_addr),
        .reg_wdata_i (reg_wdata), .reg_rdata_o (reg_rdata), .irq_o (irq),
        .arid_o (arid), .araddr_o (araddr), .arlen_o (arlen),
        .arsize_o (arsize), .arburst_o (arburst),
        .arvalid_o (arvalid), .arready_i (arready),
        .rdata_i (rdata), .rlast_i (rlast), .rvalid_i (rvalid), .rready_o (rready),
        .awid_o (awid), .awaddr_o (awaddr), .awlen_o (awlen),
        .awsize_o (awsize), .awburst_o (awburst),
        .awvalid_o (awvalid), .awready_i (awready),
        .wdata_o (wdata), .wlast_o (wlast), .wvalid_o (wvalid), .wready_i (wready),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    axi_mem_model #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_model (
        .clk (clk), .rst (rst), .stall_i (stall),
        .exp_src_i (exp_src), .exp_dst_i (exp_dst), .exp_qty_i (exp_qty),
        .cnt_clr_i (cnt_clr), .ar_cnt_o (ar_cnt), .aw_cnt_o (aw_cnt), .err_o (model_err),
        .araddr_i (araddr), .arlen_i (arlen), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rlast_o (rlast), .rvalid_o (rvalid), .rready_i (rready),
        .awaddr_i (awaddr), .awlen_i (awlen), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wlast_i (wlast), .wvalid_i (wvalid), .wready_o (wready),
        .bvalid_o (bvalid), .bready_i (bready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int unsigned rand_between(input int unsigned lo, input int unsigned hi);
        rng = xorshift32(rng);
        return lo + rng % (hi - lo + 1);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp) else begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // all register tasks start and end on a falling edge
    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we    = 1'b0;
    endtask

    task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
        reg_re   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_re   = 1'b0;
        data     = reg_rdata;
    endtask

    task automatic check_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem_model.mem[i] == ref_mem[i]) else begin
                report_failure($sformatf("mismatch at %0t: mem[%0d] got %h expected %h",
                                         $time, i, mem_model.mem[i], ref_mem[i]));
            end
        end
    endtask

    task automatic run_transfer(input int t, input bit check_status);
        logic [31:0] status;
        logic [31:0] cfg;
        int unsigned bursts;
        int unsigned sw;
        int unsigned dw;
        bursts  = (qty_tab[t] + MAX_BEATS - 1) / MAX_BEATS;
        exp_src = src_tab[t];
        exp_dst = dst_tab[t];
        exp_qty = qty_tab[t];
        cnt_clr = 1'b1;
        reg_write(SRC, src_tab[t]);
        cnt_clr = 1'b0;
        reg_write(DST, dst_tab[t]);
        reg_write(QTY, qty_tab[t]);
        reg_write(CTRL, 32'h1);
        if (check_status) begin
            reg_read(STATUS, status);
            expect_equal("STATUS", status, 32'h1);
            // config writes and a restart while busy must be dropped
            reg_write(SRC, src_tab[t] + 32'h40);
            reg_write(QTY, 32'd5);
            reg_write(CTRL, 32'h1);
        end
        while (!irq) begin
            @(negedge clk);
        end
        if (check_status) begin
            reg_read(STATUS, status);
            expect_equal("STATUS", status, 32'h2);
            // configuration still holds the values from before the start
            reg_read(SRC, cfg);
            expect_equal("SRC", cfg, src_tab[t]);
            reg_read(DST, cfg);
            expect_equal("DST", cfg, dst_tab[t]);
            reg_read(QTY, cfg);
            expect_equal("QTY", cfg, qty_tab[t]);
        end
        reg_write(CTRL, 32'h2);
        expect_equal("irq_o", 32'(irq), 32'h0);
        expect_equal("ar burst count", ar_cnt, 32'(bursts));
        expect_equal("aw burst count", aw_cnt, 32'(bursts));
        sw = src_tab[t] / 4;
        dw = dst_tab[t] / 4;
        for (int unsigned i = 0; i < qty_tab[t]; i++) begin
            ref_mem[dw + i] = ref_mem[sw + i];
        end
        check_memory();
    endtask

    always @(posedge clk) begin
        stall_rng <= xorshift32(stall_rng);
        stall     <= stall_en ? stall_rng[4:0] : 5'b0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            report_failure($sformatf("timeout, no finish after %0d cycles", cycles));
        end
    end

    always @(negedge clk) begin
        assert (!model_err) else begin
            report_failure("memory model saw a bad AXI request or beat");
        end
    end

    // fixed ID, size code 2 for 4-byte beats and burst code 1 for INCR
    always @(negedge clk) begin
        if (arvalid) begin
            expect_equal("arid_o", 32'(arid), 32'(AXI_ID));
            expect_equal("arsize_o", 32'(arsize), 32'h2);
            expect_equal("arburst_o", 32'(arburst), 32'h1);
        end
        if (awvalid) begin
            expect_equal("awid_o", 32'(awid), 32'(AXI_ID));
            expect_equal("awsize_o", 32'(awsize), 32'h2);
            expect_equal("awburst_o", 32'(awburst), 32'h1);
        end
    end

    initial begin
        logic [31:0] status;
        rst       = 1'b1;
        reg_we    = 1'b0;
        reg_re    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        stall_en  = 1'b0;
        cnt_clr   = 1'b0;
        exp_src   = '0;
        exp_dst   = '0;
        exp_qty   = '0;
        rng       = xorshift32(SEED);

        // short, long, zero, then three with stalls
        qty_tab[0] = rand_between(1, MAX_BEATS - 1);
        qty_tab[1] = rand_between(MAX_BEATS + 1, MAX_QTY);
        qty_tab[2] = 0;
        qty_tab[3] = rand_between(0, MAX_QTY);
        qty_tab[4] = rand_between(MAX_BEATS + 1, MAX_QTY);
        qty_tab[5] = rand_between(64, MAX_QTY);
        // sources in the lower half, destinations in the upper half
        for (int t = 0; t < NUM_TESTS; t++) begin
            src_tab[t] = 4 * rand_between(0, HALF_WORDS - MAX_QTY);
            dst_tab[t] = 4 * (HALF_WORDS + rand_between(0, HALF_WORDS - MAX_QTY));
            limit = limit + longint'(qty_tab[t]) * 12 + 100;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            rng = xorshift32(rng);
            mem_model.mem[i] = rng;
            ref_mem[i] = rng;
        end

        repeat (10) @(negedge clk);
        rst = 1'b0;
        expect_equal("arvalid_o", 32'(arvalid), 32'h0);
        expect_equal("awvalid_o", 32'(awvalid), 32'h0);
        expect_equal("wvalid_o", 32'(wvalid), 32'h0);
        expect_equal("rready_o", 32'(rready), 32'h0);
        expect_equal("bready_o", 32'(bready), 32'h0);
        expect_equal("irq_o", 32'(irq), 32'h0);
        reg_read(STATUS, status);
        expect_equal("STATUS", status, 32'h0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            stall_en = (t >= 3);
            run_transfer(t, t == NUM_TESTS - 1);
        end

        if (model_err) begin
            report_failure("memory model flagged an error at the end of the run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
logic/dma_pkg.sv
logic/dma_fifo.sv
logic/dma_master.sv
logic/dma_regs.sv
logic/dma_top.sv
testbench/axi_mem_model.sv
testbench/tb_dma_top.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1
out="$(verilator --binary --timing --assert -f flist.f --top-module tb_dma_top 2>&1 \
    && ./obj_dir/Vtb_dma_top 2>&1)"
echo "$out"
grep -qF "STATUS: PASS" <<< "$out" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
